//--- source/camera_pkg.sv
/*
 * Camera geometry package
 * Pixel sample width, frame side length and the widths used by the
 * exposure metering path.
 */

`default_nettype none

package camera_pkg;

    ////////////////////////////////////////////////////////////
    // Pixel format
    ////////////////////////////////////////////////////////////

    localparam int pixel_width    = 10; // One colour sample
    localparam int metering_width = 8;  // Published window average

    ////////////////////////////////////////////////////////////
    // Frame geometry
    ////////////////////////////////////////////////////////////

    // Square frame, kept small so a full frame simulates quickly
    localparam int image_size = 64;

    // Position counters are sized for sensors far larger than image_size
    localparam int counter_width = 12;

endpackage : camera_pkg

`default_nettype wire

//--- source/apb_regs_pkg.sv
/*
 * APB register map package
 * Bus widths, register offsets and control and status bit positions
 * of the metering configuration port.
 */

`default_nettype none

package apb_regs_pkg;

    localparam int apb_addr_width    = 8;
    localparam int apb_data_width    = 32;
    localparam int frame_count_width = 16; // Wrapping count of metered frames

    ////////////////////////////////////////////////////////////
    // Register offsets
    ////////////////////////////////////////////////////////////

    localparam logic [apb_addr_width-1:0] reg_ctrl   = 8'h00; // Enable and irq_enable
    localparam logic [apb_addr_width-1:0] reg_status = 8'h04; // Read clears ready
    localparam logic [apb_addr_width-1:0] reg_red    = 8'h08;
    localparam logic [apb_addr_width-1:0] reg_green  = 8'h0C;
    localparam logic [apb_addr_width-1:0] reg_blue   = 8'h10;
    localparam logic [apb_addr_width-1:0] reg_frames = 8'h14;

    // Bit positions
    localparam int ctrl_enable_bit     = 0;
    localparam int ctrl_irq_enable_bit = 1;
    localparam int status_ready_bit    = 0;

endpackage : apb_regs_pkg

`default_nettype wire

//--- source/metering_apb_decode.sv
/*
 * Metering APB register decode
 * Zero wait state APB slave. Holds the control register, builds the
 * read word from the result registers and flags unmapped offsets.
 */

`timescale 1ns/10ps
`default_nettype none

module metering_apb_decode (
    input  logic                                       clock_in,
    input  logic                                       rst_n,

    // APB slave
    input  logic [apb_regs_pkg::apb_addr_width-1:0]    paddr,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [apb_regs_pkg::apb_data_width-1:0]    pwdata,
    output logic [apb_regs_pkg::apb_data_width-1:0]    prdata,
    output logic                                       pready,
    output logic                                       pslverr,

    // Result side
    input  logic [camera_pkg::metering_width-1:0]      red_value,
    input  logic [camera_pkg::metering_width-1:0]      green_value,
    input  logic [camera_pkg::metering_width-1:0]      blue_value,
    input  logic                                       ready,
    input  logic [apb_regs_pkg::frame_count_width-1:0] frame_count,

    // Control outputs
    output logic                                       enable,
    output logic                                       irq_enable,
    output logic                                       status_read
);
    import camera_pkg::*;
    import apb_regs_pkg::*;

    logic                      access;    // Access phase of any transfer
    logic                      mapped;    // paddr hits a register
    logic [apb_data_width-1:0] read_word;

    assign access = psel && penable;

    ////////////////////////////////////////////////////////////
    // Address decode and read multiplexer
    ////////////////////////////////////////////////////////////

    always_comb begin
        read_word = '0;
        mapped    = 1'b1;
        case (paddr)
            reg_ctrl: begin
                read_word[ctrl_enable_bit]     = enable;
                read_word[ctrl_irq_enable_bit] = irq_enable;
            end
            reg_status: read_word[status_ready_bit] = ready;
            reg_red:    read_word[metering_width-1:0] = red_value;
            reg_green:  read_word[metering_width-1:0] = green_value;
            reg_blue:   read_word[metering_width-1:0] = blue_value;
            reg_frames: read_word[frame_count_width-1:0] = frame_count;
            default:    mapped = 1'b0; // Includes unaligned offsets
        endcase
    end

    assign prdata  = read_word;
    assign pready  = 1'b1;             // Never stalls
    assign pslverr = access && !mapped;

    // Result clears ready at the end of this access phase
    assign status_read = access && !pwrite && (paddr == reg_status);

    ////////////////////////////////////////////////////////////
    // Control register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            enable     <= 1'b0;
            irq_enable <= 1'b0;
        end else if (access && pwrite && (paddr == reg_ctrl)) begin
            enable     <= pwdata[ctrl_enable_bit];
            irq_enable <= pwdata[ctrl_irq_enable_bit];
        end
    end

endmodule : metering_apb_decode

`default_nettype wire

//--- source/metering.sv
/*
 * Exposure metering accumulator
 * Tracks the pixel position, sums each colour over a centred square
 * window and publishes the top bits of each sum when the frame ends.
 */

`timescale 1ns/10ps
`default_nettype none

module metering #(
    parameter int window_size = 32 // Power of two, no larger than image_size
) (
    input  logic                                  clock_in,
    input  logic                                  rst_n,
    input  logic                                  enable,

    input  logic [camera_pkg::pixel_width-1:0]    red_data,
    input  logic [camera_pkg::pixel_width-1:0]    green_data,
    input  logic [camera_pkg::pixel_width-1:0]    blue_data,
    input  logic                                  line_valid,
    input  logic                                  frame_valid,

    output logic [camera_pkg::metering_width-1:0] red_metering,
    output logic [camera_pkg::metering_width-1:0] green_metering,
    output logic [camera_pkg::metering_width-1:0] blue_metering,
    output logic                                  metering_done
);
    import camera_pkg::*;

    localparam logic [counter_width-1:0] window_start =
        counter_width'((image_size - window_size) / 2);
    localparam logic [counter_width-1:0] window_end =
        counter_width'((image_size + window_size) / 2);

    // Holds window_size^2 full scale samples without overflow
    localparam int sum_width = $clog2(window_size * window_size) + pixel_width;

    logic [counter_width-1:0] x_count;
    logic [counter_width-1:0] y_count;
    logic                     line_valid_q;
    logic                     frame_valid_q;
    logic                     frame_accepted; // enable seen at frame start
    logic                     frame_start;
    logic                     frame_end;
    logic                     in_window;

    logic [sum_width-1:0]     red_sum;
    logic [sum_width-1:0]     green_sum;
    logic [sum_width-1:0]     blue_sum;

    assign frame_start = frame_valid && !frame_valid_q;
    assign frame_end   = !frame_valid && frame_valid_q;

    assign in_window = line_valid &&
                       (x_count >= window_start) && (x_count < window_end) &&
                       (y_count >= window_start) && (y_count < window_end);

    ////////////////////////////////////////////////////////////
    // Position counters and accumulators
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            x_count      <= '0;
            y_count      <= '0;
            line_valid_q <= 1'b0;
            red_sum      <= '0;
            green_sum    <= '0;
            blue_sum     <= '0;
        end else if (!frame_valid) begin
            x_count      <= '0;                   // Idle between frames
            y_count      <= '0;
            line_valid_q <= 1'b0;
            red_sum      <= '0;
            green_sum    <= '0;
            blue_sum     <= '0;
        end else begin
            line_valid_q <= line_valid;
            if (line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
                if (line_valid_q) begin
                    y_count <= y_count + 1'b1;  // Falling edge of line_valid
                end
            end
            if (in_window) begin
                red_sum   <= red_sum + sum_width'(red_data);
                green_sum <= green_sum + sum_width'(green_data);
                blue_sum  <= blue_sum + sum_width'(blue_data);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame acceptance and publication
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            frame_valid_q  <= 1'b0;
            frame_accepted <= 1'b0;
            metering_done  <= 1'b0;
            red_metering   <= '0;
            green_metering <= '0;
            blue_metering  <= '0;
        end else begin
            frame_valid_q <= frame_valid;
            metering_done <= frame_end && frame_accepted; // One cycle pulse
            if (frame_start) begin
                frame_accepted <= enable;
            end
            // Top bits of the sum give the window mean divided by four
            if (frame_end && frame_accepted) begin
                red_metering   <= red_sum[sum_width-1 -: metering_width];
                green_metering <= green_sum[sum_width-1 -: metering_width];
                blue_metering  <= blue_sum[sum_width-1 -: metering_width];
            end
        end
    end

endmodule : metering

`default_nettype wire

//--- source/metering_result.sv
/*
 * Metering result holder
 * Latches the published averages, keeps the sticky ready flag,
 * counts metered frames and raises the interrupt.
 */

`timescale 1ns/10ps
`default_nettype none

module metering_result (
    input  logic                                       clock_in,
    input  logic                                       rst_n,

    input  logic [camera_pkg::metering_width-1:0]      red_metering,
    input  logic [camera_pkg::metering_width-1:0]      green_metering,
    input  logic [camera_pkg::metering_width-1:0]      blue_metering,
    input  logic                                       metering_done,
    input  logic                                       status_read,
    input  logic                                       irq_enable,

    output logic [camera_pkg::metering_width-1:0]      red_value,
    output logic [camera_pkg::metering_width-1:0]      green_value,
    output logic [camera_pkg::metering_width-1:0]      blue_value,
    output logic                                       ready,
    output logic [apb_regs_pkg::frame_count_width-1:0] frame_count,
    output logic                                       irq
);
    logic ready_next;
    logic irq_pending;

    // A new result wins over a status read in the same cycle
    always_comb begin
        ready_next = ready;
        if (metering_done) begin
            ready_next = 1'b1;
        end else if (status_read) begin
            ready_next = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Result registers and frame counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            red_value   <= '0;
            green_value <= '0;
            blue_value  <= '0;
            frame_count <= '0;
        end else if (metering_done) begin
            red_value   <= red_metering;   // Overwrites an unread result
            green_value <= green_metering;
            blue_value  <= blue_metering;
            frame_count <= frame_count + 1'b1; // Wraps
        end
    end

    always_ff @(posedge clock_in or negedge rst_n) begin
        if (!rst_n) begin
            ready       <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            ready       <= ready_next;
            irq_pending <= ready_next && irq_enable; // Drops on the clearing edge
        end
    end

    // Clearing irq_enable masks the request at once
    assign irq = irq_pending && irq_enable;

endmodule : metering_result

`default_nettype wire

//--- source/metering_top.sv
/*
 * Auto-exposure metering top level
 * Pixel stream statistics with an APB configuration and readout port.
 */

`timescale 1ns/10ps
`default_nettype none

module metering_top #(
    parameter int window_size = 32 // Power of two, no larger than image_size
) (
    input  logic                                    clock_in,
    input  logic                                    rst_n,

    // APB slave
    input  logic [apb_regs_pkg::apb_addr_width-1:0] paddr,
    input  logic                                    psel,
    input  logic                                    penable,
    input  logic                                    pwrite,
    input  logic [apb_regs_pkg::apb_data_width-1:0] pwdata,
    output logic [apb_regs_pkg::apb_data_width-1:0] prdata,
    output logic                                    pready,
    output logic                                    pslverr,

    // Pixel stream
    input  logic [camera_pkg::pixel_width-1:0]      red_data,
    input  logic [camera_pkg::pixel_width-1:0]      green_data,
    input  logic [camera_pkg::pixel_width-1:0]      blue_data,
    input  logic                                    line_valid,
    input  logic                                    frame_valid,

    output logic                                    irq
);
    import camera_pkg::*;
    import apb_regs_pkg::*;

    // Control from the register decode
    logic enable;
    logic irq_enable;
    logic status_read;

    // Metering to result
    logic [metering_width-1:0]    red_metering;
    logic [metering_width-1:0]    green_metering;
    logic [metering_width-1:0]    blue_metering;
    logic                         metering_done;

    // Result back to the register decode
    logic [metering_width-1:0]    red_value;
    logic [metering_width-1:0]    green_value;
    logic [metering_width-1:0]    blue_value;
    logic                         ready;
    logic [frame_count_width-1:0] frame_count;

    ////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////

    metering_apb_decode u_decode (
        .clock_in   (clock_in),
        .rst_n      (rst_n),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .red_value  (red_value),
        .green_value(green_value),
        .blue_value (blue_value),
        .ready      (ready),
        .frame_count(frame_count),
        .enable     (enable),
        .irq_enable (irq_enable),
        .status_read(status_read)
    );

    metering #(
        .window_size(window_size)
    ) u_metering (
        .clock_in      (clock_in),
        .rst_n         (rst_n),
        .enable        (enable),
        .red_data      (red_data),
        .green_data    (green_data),
        .blue_data     (blue_data),
        .line_valid    (line_valid),
        .frame_valid   (frame_valid),
        .red_metering  (red_metering),
        .green_metering(green_metering),
        .blue_metering (blue_metering),
        .metering_done (metering_done)
    );

    metering_result u_result (
        .clock_in      (clock_in),
        .rst_n         (rst_n),
        .red_metering  (red_metering),
        .green_metering(green_metering),
        .blue_metering (blue_metering),
        .metering_done (metering_done),
        .status_read   (status_read),
        .irq_enable    (irq_enable),
        .red_value     (red_value),
        .green_value   (green_value),
        .blue_value    (blue_value),
        .ready         (ready),
        .frame_count   (frame_count),
        .irq           (irq)
    );

endmodule : metering_top

`default_nettype wire

//--- test/metering_properties.sv
/*
 * Metering timing properties
 * Concurrent checks on the APB ready line, the done pulse, the ready
 * flag and the interrupt, bound into the metering top level.
 */

`timescale 1ns/10ps
`default_nettype none

module metering_properties (
    input logic clock_in,
    input logic rst_n,
    input logic pready,
    input logic metering_done,
    input logic ready,
    input logic irq_enable,
    input logic irq
);

    pready_high: assert property (@(posedge clock_in) disable iff (!rst_n)
        pready)
        else $error("pready dropped low");

    // Single cycle done pulse
    done_one_cycle: assert property (@(posedge clock_in) disable iff (!rst_n)
        metering_done |=> !metering_done)
        else $error("metering_done held for more than one cycle");

    ready_after_done: assert property (@(posedge clock_in) disable iff (!rst_n)
        metering_done |=> ready)
        else $error("ready not set one cycle after metering_done");

    ready_rise_source: assert property (@(posedge clock_in) disable iff (!rst_n)
        $rose(ready) |-> $past(metering_done))
        else $error("ready rose without a preceding metering_done");

    irq_masked: assert property (@(posedge clock_in) disable iff (!rst_n)
        (!irq_enable || !ready) |-> !irq)
        else $error("irq high while irq_enable or ready is low");

endmodule : metering_properties

bind metering_top metering_properties u_properties (
    .clock_in     (clock_in),
    .rst_n        (rst_n),
    .pready       (pready),
    .metering_done(metering_done),
    .ready        (ready),
    .irq_enable   (irq_enable),
    .irq          (irq)
);

`default_nettype wire

//--- test/metering_tb.sv
/*
 * Metering testbench
 * Streams frames from the vector file into the metering top level and
 * checks averages, status, frame count, irq and bus errors over APB.
 */

`timescale 1ns/10ps
`default_nettype none

module metering_tb;
    import camera_pkg::*;
    import apb_regs_pkg::*;

    localparam int max_vectors = 32;
    localparam int random_seed = 20;
    localparam int frame_cycle_bound = image_size * (image_size + 9) + 20; // Longest gaps

    logic                          clock_in = 1'b0;
    logic                          rst_n;
    logic [apb_addr_width-1:0]     paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [apb_data_width-1:0]     pwdata;
    logic [apb_data_width-1:0]     prdata;
    logic                          pready;
    logic                          pslverr;
    logic [pixel_width-1:0]        red_data;
    logic [pixel_width-1:0]        green_data;
    logic [pixel_width-1:0]        blue_data;
    logic                          line_valid;
    logic                          frame_valid;
    logic                          irq;

    // Vector table with pixels packed as {red, green, blue}
    string                         vec_name [max_vectors];
    logic [3*pixel_width-1:0]      even_rgb [max_vectors];
    logic [3*pixel_width-1:0]      odd_rgb [max_vectors];
    logic [metering_width-1:0]     expect_red [max_vectors];
    logic [metering_width-1:0]     expect_green [max_vectors];
    logic [metering_width-1:0]     expect_blue [max_vectors];
    int                            vector_count = 0;

    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    metering_top #(.window_size(32)) UUT (
        .clock_in(clock_in), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .red_data(red_data), .green_data(green_data), .blue_data(blue_data),
        .line_valid(line_valid), .frame_valid(frame_valid), .irq(irq)
    );

    always #4 clock_in = ~clock_in; // 8 ns period

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic int idle_gap();
        return 2 + int'($urandom % 8); // 2 to 9 idle cycles
    endfunction

    task automatic compare_value(input string test_name, input string item,
                                 input logic [apb_data_width-1:0] expected,
                                 input logic [apb_data_width-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, item, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test(input string test_name);
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
            pass_count++;
        end else begin
            $display("FAIL %s with %0d errors", test_name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    task automatic write_register(input logic [apb_addr_width-1:0] addr,
                                  input logic [apb_data_width-1:0] data,
                                  output logic err);
        @(posedge clock_in);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;                 // Setup phase
        @(posedge clock_in);
        penable <= 1'b1;
        @(negedge clock_in);
        err = pslverr;
        @(posedge clock_in);             // Write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_register(input logic [apb_addr_width-1:0] addr,
                                 output logic [apb_data_width-1:0] data,
                                 output logic err);
        @(posedge clock_in);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clock_in);
        penable <= 1'b1;
        @(negedge clock_in);
        data = prdata;                   // Stable mid access phase
        err  = pslverr;
        @(posedge clock_in);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic send_frame(input logic [3*pixel_width-1:0] even_pixel,
                              input logic [3*pixel_width-1:0] odd_pixel);
        @(posedge clock_in);
        frame_valid <= 1'b1;
        repeat (idle_gap()) @(posedge clock_in);
        for (int y = 0; y < image_size; y++) begin
            for (int x = 0; x < image_size; x++) begin
                line_valid <= 1'b1;
                {red_data, green_data, blue_data} <= ((x + y) % 2 == 0) ? even_pixel : odd_pixel;
                @(posedge clock_in);
            end
            line_valid <= 1'b0;
            {red_data, green_data, blue_data} <= '0;
            repeat (idle_gap()) @(posedge clock_in);
        end
        frame_valid <= 1'b0;
    endtask

    task automatic wait_for_ready(input string test_name);
        int waited;
        waited = 0;
        @(negedge clock_in);
        while (!UUT.ready && waited < 20) begin
            @(negedge clock_in);
            waited++;
        end
        if (!UUT.ready) begin
            $display("%s: ready did not rise within 20 cycles of frame end", test_name);
            test_errors++;
        end
    endtask

    task automatic read_vectors();
        int    fd;
        int    fields;
        int    v [9];
        string line;
        string name;
        fd = $fopen("test/metering_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file test/metering_vectors.txt");
            test_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" && vector_count < max_vectors) begin
                    fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name,
                                     v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                    if (fields != 10) begin
                        $display("Malformed vector line: %s", line);
                        test_errors++;
                    end else begin
                        for (int c = 0; c < 3; c++) begin
                            if (v[6 + c] != (v[c] + v[3 + c]) / 8) begin
                                $display("Vector %s lists a wrong average for colour %0d",
                                         name, c);
                                test_errors++;
                            end
                        end
                        vec_name[vector_count]     = name;
                        even_rgb[vector_count]     = {pixel_width'(v[0]), pixel_width'(v[1]),
                                                      pixel_width'(v[2])};
                        odd_rgb[vector_count]      = {pixel_width'(v[3]), pixel_width'(v[4]),
                                                      pixel_width'(v[5])};
                        expect_red[vector_count]   = metering_width'((v[0] + v[3]) / 8);
                        expect_green[vector_count] = metering_width'((v[1] + v[4]) / 8);
                        expect_blue[vector_count]  = metering_width'((v[2] + v[5]) / 8);
                        vector_count++;
                    end
                end
            end
            $fclose(fd);
        end
        if (vector_count == 0) begin
            $display("The vector file holds no usable test frames");
            test_errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [apb_data_width-1:0] data;
        logic                      err;
        int                        last;
        void'($urandom(random_seed));
        rst_n       <= 1'b0;
        paddr       <= '0;
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        pwdata      <= '0;
        red_data    <= '0;
        green_data  <= '0;
        blue_data   <= '0;
        line_valid  <= 1'b0;
        frame_valid <= 1'b0;

        read_vectors();
        close_test("vector_file");
        cycle_limit = 2 * (vector_count + 2) * frame_cycle_bound + 2000;
        last = (vector_count > 0) ? vector_count - 1 : 0;
        repeat (10) @(posedge clock_in);
        rst_n <= 1'b1;

        read_register(reg_ctrl, data, err);
        compare_value("reset_values", "ctrl", 0, data);
        read_register(reg_status, data, err);
        compare_value("reset_values", "status", 0, data);
        read_register(reg_frames, data, err);
        compare_value("reset_values", "frames", 0, data);
        @(negedge clock_in);
        compare_value("reset_values", "irq", 0, 32'(irq));
        close_test("reset_values");

        write_register(reg_ctrl, 32'h1, err);
        for (int i = 0; i < vector_count; i++) begin
            send_frame(even_rgb[i], odd_rgb[i]);
            wait_for_ready(vec_name[i]);
            read_register(reg_red, data, err);
            compare_value(vec_name[i], "red", 32'(expect_red[i]), data);
            read_register(reg_green, data, err);
            compare_value(vec_name[i], "green", 32'(expect_green[i]), data);
            read_register(reg_blue, data, err);
            compare_value(vec_name[i], "blue", 32'(expect_blue[i]), data);
            read_register(reg_status, data, err);
            compare_value(vec_name[i], "status first read", 32'h1, data);
            read_register(reg_status, data, err);
            compare_value(vec_name[i], "status second read", 32'h0, data);
            read_register(reg_frames, data, err);
            compare_value(vec_name[i], "frames", 32'(i + 1), data);
            close_test(vec_name[i]);
        end

        // Results must hold while metering is off
        write_register(reg_ctrl, 32'h0, err);
        send_frame({10'h155, 10'h2AA, 10'h0F0}, {10'h3C3, 10'h00F, 10'h1E1});
        repeat (10) @(negedge clock_in);
        read_register(reg_status, data, err);
        compare_value("disabled_frame", "status", 32'h0, data);
        read_register(reg_frames, data, err);
        compare_value("disabled_frame", "frames", 32'(vector_count), data);
        read_register(reg_red, data, err);
        compare_value("disabled_frame", "red", 32'(expect_red[last]), data);
        read_register(reg_green, data, err);
        compare_value("disabled_frame", "green", 32'(expect_green[last]), data);
        read_register(reg_blue, data, err);
        compare_value("disabled_frame", "blue", 32'(expect_blue[last]), data);
        close_test("disabled_frame");

        write_register(reg_ctrl, 32'h3, err);
        send_frame(even_rgb[0], odd_rgb[0]);
        wait_for_ready("irq_pulse");
        @(negedge clock_in);
        compare_value("irq_pulse", "irq after frame", 32'h1, 32'(irq));
        read_register(reg_status, data, err);
        compare_value("irq_pulse", "status", 32'h1, data);
        @(negedge clock_in);
        compare_value("irq_pulse", "irq after status read", 32'h0, 32'(irq));
        read_register(reg_frames, data, err);
        compare_value("irq_pulse", "frames", 32'(vector_count + 1), data);
        close_test("irq_pulse");

        write_register(8'h18, 32'h0, err);
        compare_value("unmapped_access", "write pslverr", 32'h1, 32'(err));
        read_register(reg_ctrl, data, err);
        compare_value("unmapped_access", "ctrl", 32'h3, data);
        compare_value("unmapped_access", "ctrl pslverr", 32'h0, 32'(err));
        read_register(8'h02, data, err);
        compare_value("unmapped_access", "unaligned pslverr", 32'h1, 32'(err));
        read_register(8'hFC, data, err);
        compare_value("unmapped_access", "read pslverr", 32'h1, 32'(err));
        close_test("unmapped_access");

        $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : metering_tb

`default_nettype wire

//--- test/metering_vectors.txt
# name  even pixel R G B  odd pixel R G B  expected average R G B (all hex)
# Pixels alternate by (x+y) parity, so each average is (even + odd) / 8
black       000 000 000  000 000 000  00 00 00
white       3FF 3FF 3FF  3FF 3FF 3FF  FF FF FF
mid_grey    200 200 200  200 200 200  80 80 80
red_only    3FF 000 000  3FF 000 000  FF 00 00
green_only  000 3FF 000  000 3FF 000  00 FF 00
blue_only   000 000 3FF  000 000 3FF  00 00 FF
checker     3FF 3FF 3FF  000 000 000  7F 7F 7F
dark_noise  008 004 00C  000 004 003  01 01 01
warm_scene  300 180 080  2C0 140 060  B8 58 1C
cool_scene  0A0 150 2F0  0C0 170 310  2C 58 C0
odd_steps   123 045 3A7  001 2FE 0D9  24 68 90
near_full   3FE 3FD 3FC  3FF 3FF 3FF  FF FF FF
rounding    007 00F 017  000 000 000  00 01 02
bright_sky  2A5 31C 3F0  1E3 2B7 3E8  91 BA FB

//--- vlog.f
source/camera_pkg.sv
source/apb_regs_pkg.sv
source/metering_apb_decode.sv
source/metering.sv
source/metering_result.sv
source/metering_top.sv
test/metering_properties.sv
test/metering_tb.sv

//--- Makefile
# Verilator flow for the metering testbench
# Run from the project root, for example: make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= metering_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
